/* run_sim.sh */
#!/bin/sh
# build and run the sys_periph testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sys_periph -f sys_periph.f \
   --Mdir obj_dir -o tb_sys_periph
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_sys_periph 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
   exit 0
else
   echo "pass message not found"
   exit 1
fi

/* sim/tb_sys_periph.sv */
`timescale 1ns/100ps

module tb_sys_periph;

   logic        sys_clk;
   logic        reset_n;
   logic        bus_sel;
   logic        bus_wr_en;
   logic        bus_rd_req;
   logic [7:0]  bus_addr;
   logic [7:0]  bus_wr_data;
   logic [7:0]  bus_rd_data;
   logic        bus_ready;
   logic        uart_line;                  // tx looped back to rx
   logic        cpu_clk_en;
   logic        irq_n;
   logic [31:0] lfsr;

   sys_periph dut0 (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .bus_sel     (bus_sel),
      .bus_wr_en   (bus_wr_en),
      .bus_rd_req  (bus_rd_req),
      .bus_addr    (bus_addr),
      .bus_wr_data (bus_wr_data),
      .bus_rd_data (bus_rd_data),
      .bus_ready   (bus_ready),
      .uart_rx     (uart_line),
      .uart_tx     (uart_line),
      .cpu_clk_en  (cpu_clk_en),
      .irq_n       (irq_n)
   );

   initial begin
      sys_clk = 1'b0;
      forever #50 sys_clk = ~sys_clk;
   end

   // inputs change and outputs are sampled 10 ns after the edge
   task automatic step();
      @(posedge sys_clk);
      #10;
   endtask

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s", what);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      step();
      bus_sel     = 1'b1;
      bus_addr    = addr;
      bus_wr_data = data;
      bus_wr_en   = 1'b1;
      step();
      bus_wr_en = 1'b0;
      bus_sel   = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      int waited;
      step();
      bus_sel    = 1'b1;
      bus_addr   = addr;
      bus_rd_req = 1'b1;
      step();
      check("read_ready_low", 32'd0, 32'(bus_ready));
      waited = 0;
      while (!bus_ready) begin
         step();
         waited++;
         if (waited > 16) timeout_fail("bus_ready after a read request");
      end
      data       = bus_rd_data;
      bus_rd_req = 1'b0;
      bus_sel    = 1'b0;
   endtask

   task automatic read_count(output logic [19:0] value);
      logic [7:0] lo;
      logic [7:0] mid;
      logic [7:0] hi;
      bus_read(sys_pkg::reg_ticks_lo, lo);
      bus_read(sys_pkg::reg_ticks_mid, mid);
      bus_read(sys_pkg::reg_ticks_hi, hi);
      value = {hi[3:0], mid, lo};
   endtask

   task automatic reset_readback();
      logic [7:0] val;
      logic [7:0] rd;
      check("reset_irq_n", 32'd1, 32'(irq_n));
      check("reset_uart_tx", 32'd1, 32'(uart_line));
      check("reset_bus_ready", 32'd1, 32'(bus_ready));
      repeat (16) begin
         step();
         check("reset_clk_en", 32'd1, 32'(cpu_clk_en));
      end
      val = 8'(rand_bits(8));
      bus_write(sys_pkg::reg_cpu_speed, val);
      bus_read(sys_pkg::reg_cpu_speed, rd);
      check("speed_readback", 32'(val & 8'h07), 32'(rd));
      val = 8'(rand_bits(8));
      bus_write(sys_pkg::reg_timer_index, val);
      bus_read(sys_pkg::reg_timer_index, rd);
      check("index_readback", 32'(val & 8'h07), 32'(rd));
      bus_write(sys_pkg::reg_cpu_speed, 8'h00);
   endtask

   task automatic throttle_rates();
      int period;
      int pulses;
      int seen;
      for (int code = 0; code < 7; code++) begin
         period = (code >= 5) ? 32 : (1 << code);
         bus_write(sys_pkg::reg_cpu_speed, 8'(code));
         repeat (64) step();
         pulses = 0;
         repeat (256) begin
            step();
            if (cpu_clk_en) pulses++;
         end
         seen = (pulses >= 256 / period - 1 && pulses <= 256 / period + 1) ?
                256 / period : pulses;   // one pulse of slack
         check($sformatf("throttle_speed%0d", code), 32'(256 / period), 32'(seen));
      end
      bus_write(sys_pkg::reg_cpu_speed, 8'h00);
   endtask

   task automatic timer_interrupt();
      logic [2:0]  idx;
      logic [19:0] ticks;
      logic [7:0]  rd;
      int          waited;
      idx   = 3'(rand_bits(3));
      ticks = 20'd8 + 20'(rand_bits(5));
      bus_write(sys_pkg::reg_timer_index, 8'(idx));
      bus_write(sys_pkg::reg_ticks_lo, ticks[7:0]);
      bus_write(sys_pkg::reg_ticks_mid, ticks[15:8]);
      bus_write(sys_pkg::reg_ticks_hi, 8'(ticks[19:16]));
      bus_write(sys_pkg::reg_timer_load, 8'h01);
      bus_write(sys_pkg::reg_timer_enable, 8'h01);
      waited = 0;
      while (irq_n) begin
         step();
         waited++;
         if (waited > int'(ticks) + 2) timeout_fail("irq_n from the timer");
      end
      bus_read(sys_pkg::reg_irq, rd);
      check("irq_status", 32'(8'h80 >> idx), 32'(rd));   // timer 0 in bit 7
      bus_write(sys_pkg::reg_timer_enable, 8'h00);
      bus_write(sys_pkg::reg_irq, 8'h01);
      bus_read(sys_pkg::reg_irq, rd);
      check("irq_after_ack", 32'd0, 32'(rd));
      check("irq_n_after_ack", 32'd1, 32'(irq_n));
   endtask

   task automatic timer_count_readback();
      logic [2:0]  idx;
      logic [19:0] ticks;
      logic [19:0] first;
      logic [19:0] second;
      int          run;
      idx   = 3'(rand_bits(3));
      ticks = 20'h80000 | 20'(rand_bits(16));
      run   = 40 + int'(rand_bits(5));
      bus_write(sys_pkg::reg_timer_index, 8'(idx));
      bus_write(sys_pkg::reg_ticks_lo, ticks[7:0]);
      bus_write(sys_pkg::reg_ticks_mid, ticks[15:8]);
      bus_write(sys_pkg::reg_ticks_hi, 8'(ticks[19:16]));
      bus_write(sys_pkg::reg_timer_load, 8'h01);
      bus_write(sys_pkg::reg_timer_enable, 8'h01);
      repeat (run) step();
      bus_write(sys_pkg::reg_timer_enable, 8'h00);
      read_count(first);
      read_count(second);
      check("count_in_range", 32'd1, 32'(first <= ticks));
      check("count_stable", 32'(first), 32'(second));
      // counts on the edges from enable up to and including disable
      check("count_value", 32'(run + 2), 32'(first));
   endtask

   task automatic uart_loopback();
      logic [7:0] b;
      logic [7:0] status;
      logic [7:0] rd;
      int         polls;
      for (int n = 0; n < 4; n++) begin
         b = 8'(rand_bits(8));
         bus_write(sys_pkg::reg_uart_data, b);
         polls  = 0;
         status = 8'h00;
         while (!status[0]) begin
            bus_read(sys_pkg::reg_uart_status, status);
            polls++;
            if (polls > 12 * sys_pkg::uart_clks_per_bit) timeout_fail("uart rx_avail");
         end
         // rx_avail comes half a bit before the frame ends
         polls = 0;
         while (status[1]) begin
            bus_read(sys_pkg::reg_uart_status, status);
            polls++;
            if (polls > sys_pkg::uart_clks_per_bit / 4 + 1) timeout_fail("end of uart frame");
         end
         check("uart_avail_held", 32'd1, 32'(status[0]));
         bus_read(sys_pkg::reg_uart_data, rd);
         check($sformatf("uart_data%0d", n), 32'(b), 32'(rd));
         bus_read(sys_pkg::reg_uart_status, status);
         check("uart_avail_clear", 32'd0, 32'(status[0]));
      end
   endtask

   initial begin
      lfsr        = 32'h7ee023ce;
      reset_n     = 1'b0;
      bus_sel     = 1'b0;
      bus_wr_en   = 1'b0;
      bus_rd_req  = 1'b0;
      bus_addr    = 8'h00;
      bus_wr_data = 8'h00;
      repeat (4) step();
      reset_n = 1'b1;
      reset_readback();
      throttle_rates();
      timer_interrupt();
      timer_count_readback();
      uart_loopback();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* src/cpu_throttle.sv */
`timescale 1ns/100ps

module cpu_throttle (
   input  logic                        sys_clk,
   input  logic                        reset_n,
   input  logic [sys_pkg::speed_w-1:0] speed,
   output logic                        clk_en
);

   logic [sys_pkg::throttle_w-1:0] div_cnt;
   logic [sys_pkg::throttle_w-1:0] phase;
   logic                           sel_phase;
   logic                           sel_phase_q;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // inverted so each rate rises where its low bits wrap
   assign phase = ~div_cnt;

   always_comb begin
      if (speed == '0) begin
         sel_phase = 1'b1;
      end else if (speed >= sys_pkg::speed_w'(sys_pkg::throttle_w)) begin
         sel_phase = phase[sys_pkg::throttle_w-1];    // slowest rate
      end else begin
         sel_phase = phase[speed - 1'b1];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         sel_phase_q <= 1'b0;
         clk_en      <= 1'b1;
      end else begin
         sel_phase_q <= sel_phase;
         clk_en      <= (speed == '0) | (sel_phase & ~sel_phase_q);
      end
   end

endmodule

/* src/sys_periph.sv */
`timescale 1ns/100ps

module sys_periph (
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic       bus_sel,
   input  logic       bus_wr_en,
   input  logic       bus_rd_req,
   input  logic [7:0] bus_addr,
   input  logic [7:0] bus_wr_data,
   output logic [7:0] bus_rd_data,
   output logic       bus_ready,
   input  logic       uart_rx,
   output logic       uart_tx,
   output logic       cpu_clk_en,
   output logic       irq_n
);

   logic [sys_pkg::speed_w-1:0]    cpu_speed;
   logic [sys_pkg::num_timers-1:0] timer_enable;
   logic [sys_pkg::num_timers-1:0] timer_load;
   logic [sys_pkg::num_timers-1:0] timer_ack;
   logic [sys_pkg::num_timers-1:0] timer_irq;
   logic [sys_pkg::timer_w-1:0]    timer_ticks [sys_pkg::num_timers];
   logic [sys_pkg::timer_w-1:0]    timer_value [sys_pkg::num_timers];
   logic [7:0]                     tx_data;
   logic                           tx_start;
   logic                           tx_busy;
   logic                           rx_pop;
   logic [7:0]                     rx_data;
   logic                           rx_avail;
   logic                           rx_wait;

   sys_regs regs0 (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .bus_sel      (bus_sel),
      .bus_wr_en    (bus_wr_en),
      .bus_rd_req   (bus_rd_req),
      .bus_addr     (bus_addr),
      .bus_wr_data  (bus_wr_data),
      .bus_rd_data  (bus_rd_data),
      .bus_ready    (bus_ready),
      .cpu_speed    (cpu_speed),
      .timer_enable (timer_enable),
      .timer_load   (timer_load),
      .timer_ack    (timer_ack),
      .timer_ticks  (timer_ticks),
      .timer_value  (timer_value),
      .timer_irq    (timer_irq),
      .tx_data      (tx_data),
      .tx_start     (tx_start),
      .tx_busy      (tx_busy),
      .rx_pop       (rx_pop),
      .rx_data      (rx_data),
      .rx_avail     (rx_avail),
      .rx_wait      (rx_wait)
   );

   for (genvar i = 0; i < sys_pkg::num_timers; i++) begin : gen_timers
      sys_timer timer0 (
         .sys_clk   (sys_clk),
         .reset_n   (reset_n),
         .enable    (timer_enable[i]),
         .load      (timer_load[i]),
         .ack       (timer_ack[i]),
         .max_ticks (timer_ticks[i]),
         .value     (timer_value[i]),
         .irq       (timer_irq[i])
      );
   end

   cpu_throttle throttle0 (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .speed   (cpu_speed),
      .clk_en  (cpu_clk_en)
   );

   uart uart0 (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .rx       (uart_rx),
      .tx       (uart_tx),
      .tx_data  (tx_data),
      .tx_start (tx_start),
      .tx_busy  (tx_busy),
      .rx_data  (rx_data),
      .rx_avail (rx_avail),
      .rx_pop   (rx_pop),
      .rx_wait  (rx_wait)
   );

   assign irq_n = ~|timer_irq;   // any timer flag pulls irq low

endmodule

/* src/sys_pkg.sv */
package sys_pkg;

   // timer bank
   localparam int num_timers  = 8;                    // also width of irq status byte
   localparam int timer_w     = 20;
   localparam int timer_idx_w = $clog2(num_timers);

   // register offsets inside the 0x93xx window
   localparam logic [7:0] reg_cpu_speed    = 8'h00;
   localparam logic [7:0] reg_timer_index  = 8'h01;
   localparam logic [7:0] reg_ticks_lo     = 8'h02;
   localparam logic [7:0] reg_ticks_mid    = 8'h03;
   localparam logic [7:0] reg_ticks_hi     = 8'h04;
   localparam logic [7:0] reg_timer_load   = 8'h05;
   localparam logic [7:0] reg_timer_enable = 8'h06;
   localparam logic [7:0] reg_irq          = 8'h07;  // read status, write ack
   localparam logic [7:0] reg_uart_status  = 8'h08;
   localparam logic [7:0] reg_uart_data    = 8'h09;

   // cpu throttle
   // code n gives one enable every 2**n cycles, codes above 4 saturate at 32
   localparam int speed_w    = 3;
   localparam int throttle_w = 5;

   // uart bit timing
   localparam int uart_clks_per_bit = 16;             // small value for simulation
   localparam int uart_cnt_w        = $clog2(uart_clks_per_bit);

endpackage

/* src/sys_regs.sv */
`timescale 1ns/100ps

module sys_regs (
   input  logic                               sys_clk,
   input  logic                               reset_n,
   input  logic                               bus_sel,
   input  logic                               bus_wr_en,
   input  logic                               bus_rd_req,
   input  logic [7:0]                         bus_addr,
   input  logic [7:0]                         bus_wr_data,
   output logic [7:0]                         bus_rd_data,
   output logic                               bus_ready,
   output logic [sys_pkg::speed_w-1:0]        cpu_speed,
   output logic [sys_pkg::num_timers-1:0]     timer_enable,
   output logic [sys_pkg::num_timers-1:0]     timer_load,
   output logic [sys_pkg::num_timers-1:0]     timer_ack,
   output logic [sys_pkg::timer_w-1:0]        timer_ticks [sys_pkg::num_timers],
   input  logic [sys_pkg::timer_w-1:0]        timer_value [sys_pkg::num_timers],
   input  logic [sys_pkg::num_timers-1:0]     timer_irq,
   output logic [7:0]                         tx_data,
   output logic                               tx_start,
   input  logic                               tx_busy,
   output logic                               rx_pop,
   input  logic [7:0]                         rx_data,
   input  logic                               rx_avail,
   input  logic                               rx_wait
);

   logic                            wr;
   logic [sys_pkg::timer_idx_w-1:0] timer_index;
   logic [sys_pkg::num_timers-1:0]  irq_rev;
   logic                            rd_req_q;
   logic                            rd_rise;
   logic                            rd_active;
   logic                            rd_settle;

   assign wr      = bus_sel & bus_wr_en;
   assign rd_rise = bus_sel & bus_rd_req & ~rd_req_q;

   // control registers
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         cpu_speed    <= '0;
         timer_index  <= '0;
         timer_enable <= '0;
         for (int i = 0; i < sys_pkg::num_timers; i++) begin
            timer_ticks[i] <= '0;
         end
      end else if (wr) begin
         case (bus_addr)
            sys_pkg::reg_cpu_speed:    cpu_speed <= bus_wr_data[sys_pkg::speed_w-1:0];
            sys_pkg::reg_timer_index:  timer_index <= bus_wr_data[sys_pkg::timer_idx_w-1:0];
            sys_pkg::reg_ticks_lo:     timer_ticks[timer_index][7:0] <= bus_wr_data;
            sys_pkg::reg_ticks_mid:    timer_ticks[timer_index][15:8] <= bus_wr_data;
            sys_pkg::reg_ticks_hi:
               timer_ticks[timer_index][sys_pkg::timer_w-1:16] <=
                  bus_wr_data[sys_pkg::timer_w-17:0];
            sys_pkg::reg_timer_enable: timer_enable[timer_index] <= bus_wr_data[0];
            default: ;
         endcase
      end
   end

   // strobes go out on the write cycle itself
   always_comb begin
      timer_load = '0;
      timer_ack  = '0;
      if (wr && bus_addr == sys_pkg::reg_timer_load) begin
         timer_load[timer_index] = 1'b1;
      end
      if (wr && bus_addr == sys_pkg::reg_irq) begin
         timer_ack[timer_index] = 1'b1;
      end
   end

   assign tx_data  = bus_wr_data;
   assign tx_start = wr && bus_addr == sys_pkg::reg_uart_data && !tx_busy;  // drop if busy

   // timer 0 ends up in bit 7, handy for bit tests on the cpu
   always_comb begin
      for (int i = 0; i < sys_pkg::num_timers; i++) begin
         irq_rev[i] = timer_irq[sys_pkg::num_timers-1-i];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (bus_sel) begin
         case (bus_addr)
            sys_pkg::reg_cpu_speed:    bus_rd_data <= 8'(cpu_speed);
            sys_pkg::reg_timer_index:  bus_rd_data <= 8'(timer_index);
            sys_pkg::reg_ticks_lo:     bus_rd_data <= timer_value[timer_index][7:0];
            sys_pkg::reg_ticks_mid:    bus_rd_data <= timer_value[timer_index][15:8];
            sys_pkg::reg_ticks_hi:
               bus_rd_data <= 8'(timer_value[timer_index][sys_pkg::timer_w-1:16]);
            sys_pkg::reg_timer_enable: bus_rd_data <= 8'(timer_enable[timer_index]);
            sys_pkg::reg_irq:          bus_rd_data <= irq_rev;
            sys_pkg::reg_uart_status:  bus_rd_data <= {6'b0, tx_busy, rx_avail};
            sys_pkg::reg_uart_data:    bus_rd_data <= rx_data;
            default:                   bus_rd_data <= 8'h00;
         endcase
      end
   end

   // read handshake, ready low at least two cycles
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rd_req_q  <= 1'b0;
         rd_active <= 1'b0;
         rd_settle <= 1'b0;
         rx_pop    <= 1'b0;
      end else begin
         rd_req_q <= bus_rd_req;
         rx_pop   <= rd_rise && bus_addr == sys_pkg::reg_uart_data;
         if (rd_rise) begin
            rd_active <= 1'b1;
            rd_settle <= 1'b1;
         end else if (rd_active) begin
            rd_settle <= 1'b0;
            if (!rd_settle && !rx_pop && !rx_wait) begin
               rd_active <= 1'b0;   // pop done
            end
         end
      end
   end

   assign bus_ready = ~rd_active;

   // cpu never writes and reads at once
   a_no_wr_rd: assert property (@(posedge sys_clk) disable iff (!reset_n)
      bus_sel |-> !(bus_wr_en && bus_rd_req));

endmodule

/* src/sys_timer.sv */
`timescale 1ns/100ps

module sys_timer (
   input  logic                        sys_clk,
   input  logic                        reset_n,
   input  logic                        enable,
   input  logic                        load,
   input  logic                        ack,
   input  logic [sys_pkg::timer_w-1:0] max_ticks,
   output logic [sys_pkg::timer_w-1:0] value,
   output logic                        irq
);

   logic terminal;

   assign terminal = enable && !load && value == max_ticks;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         value <= '0;
      end else if (load) begin
         value <= '0;
      end else if (enable) begin
         if (terminal) begin
            value <= '0;               // wrap on terminal count
         end else begin
            value <= value + 1'b1;
         end
      end
   end

   // sticky flag, new terminal count beats ack
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         irq <= 1'b0;
      end else if (terminal) begin
         irq <= 1'b1;
      end else if (ack) begin
         irq <= 1'b0;
      end
   end

   a_irq_needs_enable: assert property (@(posedge sys_clk) disable iff (!reset_n)
      $rose(irq) |-> $past(enable));

endmodule

/* src/uart.sv */
`timescale 1ns/100ps

module uart (
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic       rx,
   output logic       tx,
   input  logic [7:0] tx_data,
   input  logic       tx_start,
   output logic       tx_busy,
   output logic [7:0] rx_data,
   output logic       rx_avail,
   input  logic       rx_pop,
   output logic       rx_wait
);

   localparam int cw = sys_pkg::uart_cnt_w;

   logic [cw-1:0] tx_clk_cnt;
   logic [3:0]    tx_bit_cnt;
   logic [8:0]    tx_shift;
   logic [1:0]    rx_sync;
   logic          rx_s;
   logic          rx_busy;
   logic [cw-1:0] rx_clk_cnt;
   logic [3:0]    rx_bit_cnt;
   logic [7:0]    rx_shift;

   // transmitter, start bit goes out on the clock after tx_start
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         tx         <= 1'b1;
         tx_busy    <= 1'b0;
         tx_clk_cnt <= '0;
         tx_bit_cnt <= '0;
      end else if (tx_start) begin
         tx         <= 1'b0;
         tx_busy    <= 1'b1;
         tx_clk_cnt <= '0;
         tx_bit_cnt <= '0;
      end else if (tx_busy) begin
         tx_clk_cnt <= tx_clk_cnt + 1'b1;
         if (tx_clk_cnt == cw'(sys_pkg::uart_clks_per_bit - 1)) begin
            tx_clk_cnt <= '0;
            if (tx_bit_cnt == 4'd9) begin
               tx_busy <= 1'b0;               // stop bit done
            end else begin
               tx         <= tx_shift[0];
               tx_bit_cnt <= tx_bit_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (tx_start) begin
         tx_shift <= {1'b1, tx_data};      // stop bit behind the data
      end else if (tx_busy && tx_clk_cnt == cw'(sys_pkg::uart_clks_per_bit - 1)) begin
         tx_shift <= {1'b1, tx_shift[8:1]};
      end
   end

   assign rx_s = rx_sync[1];

   // receiver, counter preloaded to half a bit so samples land mid-bit
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rx_sync    <= 2'b11;
         rx_busy    <= 1'b0;
         rx_clk_cnt <= '0;
         rx_bit_cnt <= '0;
         rx_avail   <= 1'b0;
         rx_wait    <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], rx};
         rx_wait <= rx_pop;
         if (rx_pop) begin
            rx_avail <= 1'b0;
         end
         if (!rx_busy) begin
            if (!rx_s) begin
               rx_busy    <= 1'b1;
               rx_clk_cnt <= cw'(sys_pkg::uart_clks_per_bit / 2);
               rx_bit_cnt <= '0;
            end
         end else begin
            rx_clk_cnt <= rx_clk_cnt + 1'b1;
            if (rx_clk_cnt == cw'(sys_pkg::uart_clks_per_bit - 1)) begin
               rx_clk_cnt <= '0;
               rx_bit_cnt <= rx_bit_cnt + 1'b1;
               if (rx_bit_cnt == 4'd0 && rx_s) begin
                  rx_busy <= 1'b0;            // glitch, not a start bit
               end else if (rx_bit_cnt == 4'd9) begin
                  rx_busy <= 1'b0;
                  if (rx_s) begin
                     rx_data  <= rx_shift;    // overwrites an unread byte
                     rx_avail <= 1'b1;
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rx_busy && rx_clk_cnt == cw'(sys_pkg::uart_clks_per_bit - 1) &&
          rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9) begin
         rx_shift <= {rx_s, rx_shift[7:1]};   // lsb first
      end
   end

   a_no_start_busy: assert property (@(posedge sys_clk) disable iff (!reset_n)
      tx_start |-> !tx_busy);

endmodule

/* sys_periph.f */
src/sys_pkg.sv
src/sys_regs.sv
src/sys_timer.sv
src/cpu_throttle.sv
src/uart.sv
src/sys_periph.sv
sim/tb_sys_periph.sv
